// ==== build.f ====
+incdir+dv
verilog/frv_core_pkg.sv
verilog/frv_exu_pkg.sv
verilog/frv_alu.sv
verilog/frv_alu_decode.sv
verilog/frv_alu_lane.sv
verilog/frv_alu_dispatch.sv
verilog/frv_alu_collect.sv
verilog/frv_alu_exu.sv
dv/tb_frv_alu_exu.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_frv_alu_exu
FILELIST  ?= build.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@grep -q "TEST PASSED" $(LOG) || (echo "simulation ended without a result"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== dv/alu_vectors.svh ====
// Rows stream in order, rd is only a tag; group 1 arithmetic, 2 logic and packing, 3 shifts
// Columns: group, op, opr_a, opr_b, rd, expected result
add_row(1, frv_exu_pkg::ALU_ADD,    32'h7FFFFFFF, 32'h00000001, 5'd1,  32'h80000000);
add_row(1, frv_exu_pkg::ALU_SUB,    32'h00000001, 32'h00000002, 5'd2,  32'hFFFFFFFF);
add_row(1, frv_exu_pkg::ALU_SLT,    32'hFFFFFFFF, 32'h00000001, 5'd3,  32'h00000001);
add_row(1, frv_exu_pkg::ALU_SLTU,   32'hFFFFFFFF, 32'h00000001, 5'd4,  32'h00000000);
add_row(1, frv_exu_pkg::ALU_MIN,    32'h80000000, 32'h00000005, 5'd5,  32'h80000000);
add_row(1, frv_exu_pkg::ALU_MAX,    32'h80000000, 32'h00000005, 5'd6,  32'h00000005);
add_row(1, frv_exu_pkg::ALU_MINU,   32'h80000000, 32'h00000005, 5'd7,  32'h00000005);
add_row(1, frv_exu_pkg::ALU_MAXU,   32'h80000000, 32'h00000005, 5'd8,  32'h80000000);
add_row(2, frv_exu_pkg::ALU_XOR,    32'hF0F0A5A5, 32'h0FF0FF00, 5'd9,  32'hFF005AA5);
add_row(2, frv_exu_pkg::ALU_OR,     32'hF0F0A5A5, 32'h0FF0FF00, 5'd10, 32'hFFF0FFA5);
add_row(2, frv_exu_pkg::ALU_AND,    32'hF0F0A5A5, 32'h0FF0FF00, 5'd11, 32'h00F0A500);
add_row(2, frv_exu_pkg::ALU_XNOR,   32'hF0F0A5A5, 32'h0FF0FF00, 5'd12, 32'h00FFA55A);
add_row(2, frv_exu_pkg::ALU_ORN,    32'hF0F0A5A5, 32'h0FF0FF00, 5'd13, 32'hF0FFA5FF);
add_row(2, frv_exu_pkg::ALU_ANDN,   32'hF0F0A5A5, 32'h0FF0FF00, 5'd14, 32'hF00000A5);
add_row(2, frv_exu_pkg::ALU_PACK,   32'h12345678, 32'h9ABCDEF0, 5'd15, 32'hDEF05678);
add_row(2, frv_exu_pkg::ALU_PACKH,  32'h12345678, 32'h9ABCDEF0, 5'd16, 32'h0000F078);
add_row(2, frv_exu_pkg::ALU_PACKU,  32'h12345678, 32'h9ABCDEF0, 5'd17, 32'h9ABC1234);
add_row(2, frv_exu_pkg::ALU_SEXTB,  32'h12345680, 32'h00000000, 5'd18, 32'hFFFFFF80);
add_row(2, frv_exu_pkg::ALU_SEXTH,  32'h1234F00D, 32'h00000000, 5'd19, 32'hFFFFF00D);
add_row(3, frv_exu_pkg::ALU_SLL,    32'h80000011, 32'h00000000, 5'd20, 32'h80000011);
add_row(3, frv_exu_pkg::ALU_SLL,    32'h80000011, 32'h00000021, 5'd21, 32'h00000022);
add_row(3, frv_exu_pkg::ALU_SRL,    32'h80000011, 32'h00000010, 5'd22, 32'h00008000);
add_row(3, frv_exu_pkg::ALU_SRA,    32'h80000011, 32'h0000001F, 5'd23, 32'hFFFFFFFF);
add_row(3, frv_exu_pkg::ALU_SRA,    32'h80000011, 32'h00000001, 5'd24, 32'hC0000008);
add_row(3, frv_exu_pkg::ALU_ROR,    32'h80000011, 32'h00000010, 5'd25, 32'h00118000);
add_row(3, frv_exu_pkg::ALU_ROL,    32'h80000011, 32'h00000001, 5'd26, 32'h00000023);
add_row(3, frv_exu_pkg::ALU_ROL,    32'h80000011, 32'h0000001F, 5'd27, 32'hC0000008);
add_row(3, frv_exu_pkg::ALU_SLO,    32'h80000011, 32'h00000010, 5'd28, 32'h0011FFFF);
add_row(3, frv_exu_pkg::ALU_SRO,    32'h00000011, 32'h00000001, 5'd29, 32'h80000008);
add_row(3, frv_exu_pkg::ALU_GREV,   32'h12345678, 32'h00000018, 5'd30, 32'h78563412);
add_row(3, frv_exu_pkg::ALU_GREV,   32'h12345678, 32'h0000001F, 5'd31, 32'h1E6A2C48);
add_row(3, frv_exu_pkg::ALU_GREV,   32'h12345678, 32'h00000004, 5'd0,  32'h21436587);
add_row(3, frv_exu_pkg::ALU_SHFL,   32'h0000FFFF, 32'h0000000F, 5'd1,  32'h55555555);
add_row(3, frv_exu_pkg::ALU_SHFL,   32'h12345678, 32'h00000008, 5'd2,  32'h12563478);
add_row(3, frv_exu_pkg::ALU_UNSHFL, 32'h55555555, 32'h0000000F, 5'd3,  32'h0000FFFF);
add_row(3, frv_exu_pkg::ALU_UNSHFL, 32'h12563478, 32'h00000008, 5'd4,  32'h12345678);

// ==== dv/tb_frv_alu_exu.sv ====
// Needs more table rows than LANES; every wait gives up after TIMEOUT idle cycles
`timescale 1ns/1ns
`default_nettype none

module tb_frv_alu_exu;

    localparam int TIMEOUT = 200; // Idle cycles before a wait gives up

    logic                   g_clk;
    logic                   rst;
    logic                   in_valid;
    logic                   in_ready;
    frv_exu_pkg::alu_op_t   in_op;
    frv_core_pkg::xlen_t    in_opr_a;
    frv_core_pkg::xlen_t    in_opr_b;
    frv_core_pkg::reg_idx_t in_rd;
    logic                   out_valid;
    logic                   out_ready;
    frv_core_pkg::xlen_t    out_result;
    frv_core_pkg::reg_idx_t out_rd;

    int                     seed = 39;
    int                     errors = 0;
    int                     tests = 0;
    int                     fails = 0;
    int                     grp_err [4] = '{0, 0, 0, 0}; // Index 0 for checks outside the table
    int                     row_grp [$];
    frv_exu_pkg::alu_op_t   row_op [$];
    frv_core_pkg::xlen_t    row_a [$];
    frv_core_pkg::xlen_t    row_b [$];
    frv_core_pkg::reg_idx_t row_rd [$];
    frv_core_pkg::xlen_t    row_res [$];

    frv_alu_exu i_dut (.*);

    initial begin
        g_clk = 1'b0;
        forever #20 g_clk = ~g_clk; // 40 ns period
    end

    task automatic add_row(input int grp, input frv_exu_pkg::alu_op_t op,
        input frv_core_pkg::xlen_t a, input frv_core_pkg::xlen_t b,
        input frv_core_pkg::reg_idx_t rd, input frv_core_pkg::xlen_t res);
        row_grp.push_back(grp);
        row_op.push_back(op);
        row_a.push_back(a);
        row_b.push_back(b);
        row_rd.push_back(rd);
        row_res.push_back(res);
    endtask

    task automatic load_table();
        `include "alu_vectors.svh"
    endtask

    // --------------------
    // Compare tasks

    task automatic check_word(input string name, input frv_core_pkg::xlen_t got,
        input frv_core_pkg::xlen_t exp, input int grp);
        if (got !== exp) begin
            $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
            errors++;
            grp_err[grp]++;
        end
    endtask

    task automatic check_rd(input string name, input frv_core_pkg::reg_idx_t got,
        input frv_core_pkg::reg_idx_t exp, input int grp);
        if (got !== exp) begin
            $display("mismatch at %0t: %s got %0d expected %0d", $time, name, got, exp);
            errors++;
            grp_err[grp]++;
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("mismatch at %0t: %s got %b expected %b", $time, name, got, exp);
            errors++;
            grp_err[0]++;
        end
    endtask

    task automatic report(input string name, input bit ok);
        tests++;
        if (!ok) fails++;
        $display("test %-26s %s", name, ok ? "pass" : "fail");
    endtask

    // --------------------
    // Producer and consumer

    task automatic drive_row(input int i);
        in_op    <= row_op[i];
        in_opr_a <= row_a[i];
        in_opr_b <= row_b[i];
        in_rd    <= row_rd[i];
    endtask

    task automatic produce(input int count);
        int wait_cyc;
        for (int i = 0; i < count; i++) begin
            in_valid <= 1'b1;
            drive_row(i);
            wait_cyc = 0;
            do begin
                @(posedge g_clk);
                wait_cyc++;
            end while (!in_ready && wait_cyc < TIMEOUT);
            if (!in_ready) begin
                $display("Timeout: request %0d was never accepted", i);
                errors++;
                break;
            end
        end
        in_valid <= 1'b0;
    endtask

    task automatic consume(input int count, input bit random_ready);
        int idle;
        int k;
        int rnd;
        k = 0;
        idle = 0;
        while (k < count && idle < TIMEOUT) begin
            @(posedge g_clk);
            idle++;
            if (out_valid && out_ready) begin
                check_word("out_result", out_result, row_res[k], row_grp[k]);
                check_rd("out_rd", out_rd, row_rd[k], row_grp[k]);
                k++;
                idle = 0;
            end
            rnd = $random(seed);
            out_ready <= random_ready ? rnd[0] : 1'b1;
        end
        if (k < count) begin
            $display("Timeout: only %0d of %0d results arrived", k, count);
            errors++;
        end
    endtask

    // --------------------
    // Test sequence

    initial begin
        int base;
        int filled;
        rst       <= 1'b1;
        in_valid  <= 1'b0;
        in_op     <= frv_exu_pkg::ALU_ADD;
        in_opr_a  <= '0;
        in_opr_b  <= '0;
        in_rd     <= '0;
        out_ready <= 1'b0;
        load_table();

        for (int c = 0; c < 4; c++) begin
            @(posedge g_clk);
            if (c > 0) check_flag("out_valid", out_valid, 1'b0); // Registers settle at edge 1
        end
        rst <= 1'b0;
        @(posedge g_clk);
        check_flag("out_valid", out_valid, 1'b0);
        report("reset state", errors == 0);

        base = errors;
        fork
            produce(row_op.size());
            consume(row_op.size(), 1'b1);
        join
        out_ready <= 1'b1;
        for (int c = 0; c < frv_exu_pkg::LANES + 2; c++) begin
            @(posedge g_clk);
            check_flag("out_valid", out_valid, 1'b0); // Nothing left after the last row
        end
        report("arithmetic and compare", grp_err[1] == 0);
        report("logic and packing", grp_err[2] == 0);
        report("shifts and permutations", grp_err[3] == 0);
        report("order under back-pressure", errors == base);

        base = errors;
        out_ready <= 1'b0;
        in_valid  <= 1'b1;
        drive_row(0);
        filled = 0;
        for (int c = 0; c < frv_exu_pkg::LANES + 3; c++) begin
            @(posedge g_clk);
            if (in_ready) begin
                filled++;
                drive_row(filled);
            end
        end
        if (filled != frv_exu_pkg::LANES) begin
            $display("Fill: %0d requests accepted with out_ready low, expected %0d",
                     filled, frv_exu_pkg::LANES);
            errors++;
        end
        in_valid  <= 1'b0;
        out_ready <= 1'b1;
        consume(frv_exu_pkg::LANES, 1'b0);
        report("fill and drain", errors == base);

        $display("%0d tests, %0d failed, %0d errors", tests, fails, errors);
        if (errors == 0 && fails == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog/frv_alu_exu.sv ====
// In-order execute unit with LANES ALU lanes; 1-cycle latency, one request per cycle
`timescale 1ns/1ns
`default_nettype none

module frv_alu_exu (
    input  logic                   g_clk,
    input  logic                   rst,
    input  logic                   in_valid,
    output logic                   in_ready,
    input  frv_exu_pkg::alu_op_t   in_op,
    input  frv_core_pkg::xlen_t    in_opr_a,
    input  frv_core_pkg::xlen_t    in_opr_b,
    input  frv_core_pkg::reg_idx_t in_rd,
    output logic                   out_valid,
    input  logic                   out_ready,
    output frv_core_pkg::xlen_t    out_result,
    output frv_core_pkg::reg_idx_t out_rd
);

    logic [frv_exu_pkg::LANES-1:0]                   req_valid;
    logic [frv_exu_pkg::LANES-1:0]                   req_ready;
    logic [frv_exu_pkg::LANES-1:0]                   res_valid;
    logic [frv_exu_pkg::LANES-1:0]                   res_ready;
    frv_core_pkg::xlen_t [frv_exu_pkg::LANES-1:0]    res_result;
    frv_core_pkg::reg_idx_t [frv_exu_pkg::LANES-1:0] res_rd;

    frv_alu_dispatch i_dispatch (
        .g_clk      (g_clk),
        .rst        (rst),
        .in_valid   (in_valid),
        .in_ready   (in_ready),
        .lane_valid (req_valid),
        .lane_ready (req_ready)
    );

    // Payload goes to every lane, only the pointed one sees valid
    for (genvar i = 0; i < frv_exu_pkg::LANES; i++) begin : g_lane
        frv_alu_lane i_lane (
            .g_clk      (g_clk),
            .rst        (rst),
            .req_valid  (req_valid[i]),
            .req_ready  (req_ready[i]),
            .req_op     (in_op),
            .req_opr_a  (in_opr_a),
            .req_opr_b  (in_opr_b),
            .req_rd     (in_rd),
            .res_valid  (res_valid[i]),
            .res_ready  (res_ready[i]),
            .res_result (res_result[i]),
            .res_rd     (res_rd[i])
        );
    end

    frv_alu_collect i_collect (
        .g_clk       (g_clk),
        .rst         (rst),
        .lane_valid  (res_valid),
        .lane_result (res_result),
        .lane_rd     (res_rd),
        .lane_ready  (res_ready),
        .out_valid   (out_valid),
        .out_ready   (out_ready),
        .out_result  (out_result),
        .out_rd      (out_rd)
    );

endmodule

`default_nettype wire

// ==== verilog/frv_alu_collect.sv ====
// Drains lanes in issue order; out_ready reaches the pointed lane only
`timescale 1ns/1ns
`default_nettype none

module frv_alu_collect (
    input  logic                                                g_clk,
    input  logic                                                rst,
    input  logic [frv_exu_pkg::LANES-1:0]                       lane_valid,
    input  frv_core_pkg::xlen_t [frv_exu_pkg::LANES-1:0]        lane_result,
    input  frv_core_pkg::reg_idx_t [frv_exu_pkg::LANES-1:0]     lane_rd,
    output logic [frv_exu_pkg::LANES-1:0]                       lane_ready,
    output logic                                                out_valid,
    input  logic                                                out_ready,
    output frv_core_pkg::xlen_t                                 out_result,
    output frv_core_pkg::reg_idx_t                              out_rd
);

    logic [frv_exu_pkg::LANE_W-1:0] ptr; // Oldest lane still in flight

    assign out_valid  = lane_valid[ptr];
    assign out_result = lane_result[ptr];
    assign out_rd     = lane_rd[ptr];
    assign lane_ready = {{(frv_exu_pkg::LANES-1){1'b0}}, out_ready} << ptr;

    always_ff @(posedge g_clk) begin
        if (rst) begin
            ptr <= '0;
        end else if (out_valid && out_ready) begin
            ptr <= ptr + 1'b1; // Follows the dispatcher's rotation
        end
    end

endmodule

`default_nettype wire

// ==== verilog/frv_alu_dispatch.sv ====
// Strict rotation with no skipping: a busy pointed lane stalls input even if others are free
`timescale 1ns/1ns
`default_nettype none

module frv_alu_dispatch (
    input  logic                          g_clk,
    input  logic                          rst,
    input  logic                          in_valid,
    output logic                          in_ready,
    output logic [frv_exu_pkg::LANES-1:0] lane_valid, // One-hot at the issue pointer
    input  logic [frv_exu_pkg::LANES-1:0] lane_ready
);

    logic [frv_exu_pkg::LANE_W-1:0] ptr; // Next lane to issue to

    assign lane_valid = {{(frv_exu_pkg::LANES-1){1'b0}}, in_valid} << ptr;
    assign in_ready   = lane_ready[ptr];

    always_ff @(posedge g_clk) begin
        if (rst) begin
            ptr <= '0;
        end else if (in_valid && in_ready) begin
            ptr <= ptr + 1'b1; // Wraps, LANES is a power of two
        end
    end

endmodule

`default_nettype wire

// ==== verilog/frv_alu_lane.sv ====
// One-entry stage with 1-cycle latency; accepts a new request in the cycle its result leaves
`timescale 1ns/1ns
`default_nettype none

module frv_alu_lane (
    input  logic                   g_clk,
    input  logic                   rst,
    input  logic                   req_valid,
    output logic                   req_ready,
    input  frv_exu_pkg::alu_op_t   req_op,
    input  frv_core_pkg::xlen_t    req_opr_a,
    input  frv_core_pkg::xlen_t    req_opr_b,
    input  frv_core_pkg::reg_idx_t req_rd,
    output logic                   res_valid,
    input  logic                   res_ready,
    output frv_core_pkg::xlen_t    res_result,
    output frv_core_pkg::reg_idx_t res_rd
);

    logic                   full; // Entry holds an undrained request
    frv_exu_pkg::alu_op_t   op;
    frv_core_pkg::xlen_t    opr_a;
    frv_core_pkg::xlen_t    opr_b;
    frv_core_pkg::reg_idx_t rd;
    frv_core_pkg::xlen_t    result;
    logic [4:0]             shamt;

    // Decoder to ALU select lines
    logic op_add, op_sub, op_slt, op_sltu, op_max, op_maxu, op_min, op_minu;
    logic op_xor, op_or, op_and, op_xnor, op_orn, op_andn;
    logic op_pack, op_packh, op_packu, op_sextb, op_sexth;
    logic op_sll, op_srl, op_sra, op_ror, op_rol, op_slo, op_sro;
    logic op_grev, op_shfl, op_unshfl, op_clz, op_ctz, op_pcnt, op_gorc;

    assign req_ready  = !full || res_ready; // Free, or draining this cycle
    assign res_valid  = full;
    assign res_result = result; // ALU works on the held operands
    assign res_rd     = rd;

    always_ff @(posedge g_clk) begin
        if (rst) begin
            full <= 1'b0;
        end else if (req_valid && req_ready) begin
            full <= 1'b1;
        end else if (res_valid && res_ready) begin
            full <= 1'b0;
        end
    end

    always_ff @(posedge g_clk) begin
        if (req_valid && req_ready) begin
            op    <= req_op;
            opr_a <= req_opr_a;
            opr_b <= req_opr_b;
            rd    <= req_rd;
        end
    end

    frv_alu_decode i_decode (.*);

    // Adder and compare outputs would go to a branch unit
    frv_alu i_alu (.*, .add_out(), .cmp_eq(), .cmp_lt(), .cmp_ltu());

endmodule

`default_nettype wire

// ==== verilog/frv_alu_decode.sv ====
// Unknown codes raise no select and give a zero result; clz, ctz, pcnt and gorc never raised
`timescale 1ns/1ns
`default_nettype none

module frv_alu_decode (
    input  frv_exu_pkg::alu_op_t op, // Operation code
    input  frv_core_pkg::xlen_t  opr_b, // Operand B, source of the shift amount
    output logic                 op_add, op_sub, op_slt, op_sltu,
    output logic                 op_max, op_maxu, op_min, op_minu,
    output logic                 op_xor, op_or, op_and,
    output logic                 op_xnor, op_orn, op_andn,
    output logic                 op_pack, op_packh, op_packu,
    output logic                 op_sextb, op_sexth,
    output logic                 op_sll, op_srl, op_sra, op_ror, op_rol,
    output logic                 op_slo, op_sro,
    output logic                 op_grev, op_shfl, op_unshfl,
    output logic                 op_clz, op_ctz, op_pcnt, op_gorc,
    output logic [4:0]           shamt // ALU shift amount
);

    assign op_add    = op == frv_exu_pkg::ALU_ADD;
    assign op_sub    = op == frv_exu_pkg::ALU_SUB;
    assign op_slt    = op == frv_exu_pkg::ALU_SLT;
    assign op_sltu   = op == frv_exu_pkg::ALU_SLTU;
    assign op_min    = op == frv_exu_pkg::ALU_MIN;
    assign op_max    = op == frv_exu_pkg::ALU_MAX;
    assign op_minu   = op == frv_exu_pkg::ALU_MINU;
    assign op_maxu   = op == frv_exu_pkg::ALU_MAXU;
    assign op_xor    = op == frv_exu_pkg::ALU_XOR;
    assign op_or     = op == frv_exu_pkg::ALU_OR;
    assign op_and    = op == frv_exu_pkg::ALU_AND;
    assign op_xnor   = op == frv_exu_pkg::ALU_XNOR;
    assign op_orn    = op == frv_exu_pkg::ALU_ORN;
    assign op_andn   = op == frv_exu_pkg::ALU_ANDN;
    assign op_pack   = op == frv_exu_pkg::ALU_PACK;
    assign op_packh  = op == frv_exu_pkg::ALU_PACKH;
    assign op_packu  = op == frv_exu_pkg::ALU_PACKU;
    assign op_sextb  = op == frv_exu_pkg::ALU_SEXTB;
    assign op_sexth  = op == frv_exu_pkg::ALU_SEXTH;
    assign op_sll    = op == frv_exu_pkg::ALU_SLL;
    assign op_srl    = op == frv_exu_pkg::ALU_SRL;
    assign op_sra    = op == frv_exu_pkg::ALU_SRA;
    assign op_ror    = op == frv_exu_pkg::ALU_ROR;
    assign op_rol    = op == frv_exu_pkg::ALU_ROL;
    assign op_slo    = op == frv_exu_pkg::ALU_SLO;
    assign op_sro    = op == frv_exu_pkg::ALU_SRO;
    assign op_grev   = op == frv_exu_pkg::ALU_GREV;
    assign op_shfl   = op == frv_exu_pkg::ALU_SHFL;
    assign op_unshfl = op == frv_exu_pkg::ALU_UNSHFL;

    // Counting and or-combine are not part of this unit
    assign op_clz  = 1'b0;
    assign op_ctz  = 1'b0;
    assign op_pcnt = 1'b0;
    assign op_gorc = 1'b0;

    assign shamt = opr_b[4:0]; // Rol also takes it as is, the ALU mirrors the operand

endmodule

`default_nettype wire

// ==== verilog/frv_alu.sv ====
// RV32 only with fixed 32-bit permutation masks; clz, ctz, pcnt and gorc selects produce nothing
`timescale 1ns/1ns
`default_nettype none

module frv_alu (
    input  frv_core_pkg::xlen_t opr_a, // Operand A
    input  frv_core_pkg::xlen_t opr_b, // Operand B, also grev/shfl control
    input  logic [4:0]          shamt, // Shift amount
    input  logic                op_add, op_sub, op_slt, op_sltu, // Arithmetic, compare
    input  logic                op_max, op_maxu, op_min, op_minu, // Min/max
    input  logic                op_xor, op_or, op_and, // Bitwise
    input  logic                op_xnor, op_orn, op_andn, // Bitwise with ~opr_b
    input  logic                op_pack, op_packh, op_packu, // Packing
    input  logic                op_sextb, op_sexth, // Sign extension
    input  logic                op_sll, op_srl, op_sra, op_ror, op_rol, // Shifts, rotates
    input  logic                op_slo, op_sro, // Shift in ones
    input  logic                op_grev, op_shfl, op_unshfl, // Permutations
    input  logic                op_clz, op_ctz, op_pcnt, op_gorc, // Not implemented
    output frv_core_pkg::xlen_t add_out, // Adder output for branch target use
    output logic                cmp_eq, // opr_a == opr_b
    output logic                cmp_lt, // Signed opr_a < opr_b
    output logic                cmp_ltu, // Unsigned opr_a < opr_b
    output frv_core_pkg::xlen_t result // Operation result
);

    // Mask a value by its one-hot select
    function automatic frv_core_pkg::xlen_t gate(input logic sel, input frv_core_pkg::xlen_t v);
        return {frv_core_pkg::XLEN{sel}} & v;
    endfunction

    // One butterfly stage of grev
    function automatic frv_core_pkg::xlen_t grev_step(input logic en,
        input frv_core_pkg::xlen_t x, input frv_core_pkg::xlen_t m1,
        input frv_core_pkg::xlen_t m2, input int n);
        return en ? (((x & m1) << n) | ((x & m2) >> n)) : x;
    endfunction

    // One swap stage of shfl/unshfl, bits outside ml|mr stay put
    function automatic frv_core_pkg::xlen_t shfl_step(input logic en,
        input frv_core_pkg::xlen_t x, input frv_core_pkg::xlen_t ml,
        input frv_core_pkg::xlen_t mr, input int n);
        return en ? ((x & ~(ml | mr)) | ((x << n) & ml) | ((x >> n) & mr)) : x;
    endfunction

    // --------------------
    // Add, sub, compare

    frv_core_pkg::xlen_t addsub_rhs;
    frv_core_pkg::xlen_t slt_result;
    frv_core_pkg::xlen_t result_min;
    frv_core_pkg::xlen_t result_max;
    logic                minmax_sel;

    assign addsub_rhs = op_sub ? ~opr_b : opr_b; // Two's complement via carry in
    assign add_out    = opr_a + addsub_rhs + frv_core_pkg::xlen_t'(op_sub);
    assign cmp_eq     = opr_a == opr_b;
    assign cmp_lt     = $signed(opr_a) < $signed(opr_b);
    assign cmp_ltu    = opr_a < opr_b;
    assign slt_result = frv_core_pkg::xlen_t'(op_slt ? cmp_lt : cmp_ltu);

    assign minmax_sel = (op_minu || op_maxu) ? cmp_ltu : cmp_lt; // High when a < b
    assign result_min = minmax_sel ? opr_a : opr_b;
    assign result_max = minmax_sel ? opr_b : opr_a;

    // --------------------
    // Bitwise, pack, sign extension

    frv_core_pkg::xlen_t opr_b_n;
    frv_core_pkg::xlen_t sign_result;
    logic                sign_bit;

    assign opr_b_n = (op_xnor || op_orn || op_andn) ? ~opr_b : opr_b;

    // Sign bit gated by its op to keep the upper bits quiet
    assign sign_bit    = (opr_a[7] && op_sextb) || (opr_a[15] && op_sexth);
    assign sign_result = {{16{sign_bit}},
                          op_sexth ? opr_a[15:8] : {8{sign_bit}},
                          opr_a[7:0]};

    // --------------------
    // Shifts and rotates

    // Left shifts run through the right shifter on bit-reversed data
    logic                                 sr_left;
    logic                                 sr_right;
    logic                                 sr_fill;
    logic                                 rotate;
    logic                                 fill_bit;
    frv_core_pkg::xlen_t                  shift_lo;
    frv_core_pkg::xlen_t                  shift_hi;
    logic [2*frv_core_pkg::XLEN-1:0]      shift_out;
    frv_core_pkg::xlen_t                  shift_out_r;
    frv_core_pkg::xlen_t                  shift_result;

    assign sr_left  = op_sll || op_rol || op_slo;
    assign sr_right = op_srl || op_ror || op_sro || op_sra;
    assign sr_fill  = op_slo || op_sro || op_sra; // Upper word not zero
    assign rotate   = op_rol || op_ror;
    assign fill_bit = opr_a[frv_core_pkg::XL] || op_slo || op_sro; // Sign for sra

    assign shift_lo = sr_left ? {<<{opr_a}} : opr_a;
    assign shift_hi = rotate  ? shift_lo :
                      sr_fill ? {frv_core_pkg::XLEN{fill_bit}} : '0;

    assign shift_out    = {shift_hi, shift_lo} >> shamt;
    assign shift_out_r  = shift_out[frv_core_pkg::XL:0];
    assign shift_result = gate(sr_left, {<<{shift_out_r}}) | gate(sr_right, shift_out_r);

    // --------------------
    // Grev, shfl, unshfl

    logic [4:0]          ctrl;
    frv_core_pkg::xlen_t grev_result;
    frv_core_pkg::xlen_t shfl_result;
    frv_core_pkg::xlen_t unshfl_result;

    assign ctrl = opr_b[4:0];

    always_comb begin
        grev_result = opr_a;
        grev_result = grev_step(ctrl[0], grev_result, 32'h55555555, 32'hAAAAAAAA, 1);
        grev_result = grev_step(ctrl[1], grev_result, 32'h33333333, 32'hCCCCCCCC, 2);
        grev_result = grev_step(ctrl[2], grev_result, 32'h0F0F0F0F, 32'hF0F0F0F0, 4);
        grev_result = grev_step(ctrl[3], grev_result, 32'h00FF00FF, 32'hFF00FF00, 8);
        grev_result = grev_step(ctrl[4], grev_result, 32'h0000FFFF, 32'hFFFF0000, 16);
    end

    // Unshfl runs the same stages in reverse order
    always_comb begin
        shfl_result = opr_a;
        shfl_result = shfl_step(ctrl[3], shfl_result, 32'h00FF0000, 32'h0000FF00, 8);
        shfl_result = shfl_step(ctrl[2], shfl_result, 32'h0F000F00, 32'h00F000F0, 4);
        shfl_result = shfl_step(ctrl[1], shfl_result, 32'h30303030, 32'h0C0C0C0C, 2);
        shfl_result = shfl_step(ctrl[0], shfl_result, 32'h44444444, 32'h22222222, 1);
        unshfl_result = opr_a;
        unshfl_result = shfl_step(ctrl[0], unshfl_result, 32'h44444444, 32'h22222222, 1);
        unshfl_result = shfl_step(ctrl[1], unshfl_result, 32'h30303030, 32'h0C0C0C0C, 2);
        unshfl_result = shfl_step(ctrl[2], unshfl_result, 32'h0F000F00, 32'h00F000F0, 4);
        unshfl_result = shfl_step(ctrl[3], unshfl_result, 32'h00FF0000, 32'h0000FF00, 8);
    end

    // --------------------
    // Result merge, selects are one-hot

    assign result = gate(op_add || op_sub, add_out)
                  | gate(op_slt || op_sltu, slt_result)
                  | gate(op_min || op_minu, result_min)
                  | gate(op_max || op_maxu, result_max)
                  | gate(op_xor || op_xnor, opr_a ^ opr_b_n)
                  | gate(op_or || op_orn, opr_a | opr_b_n)
                  | gate(op_and || op_andn, opr_a & opr_b_n)
                  | gate(op_pack, {opr_b[15:0], opr_a[15:0]})
                  | gate(op_packu, {opr_b[31:16], opr_a[31:16]})
                  | gate(op_packh, {16'b0, opr_b[7:0], opr_a[7:0]})
                  | gate(op_sextb || op_sexth, sign_result)
                  | shift_result
                  | gate(op_grev, grev_result)
                  | gate(op_shfl, shfl_result)
                  | gate(op_unshfl, unshfl_result);

endmodule

`default_nettype wire

// ==== verilog/frv_exu_pkg.sv ====
// Execute unit configuration; LANES must be a power of two (2, 4 or 8)
`default_nettype none

package frv_exu_pkg;

    localparam int LANES  = 4; // ALU lanes in the rotation
    localparam int LANE_W = $clog2(LANES); // Lane pointer width

    // Codes 29..31 are unused and decode to no select
    typedef enum logic [4:0] {
        ALU_ADD = 5'd0, ALU_SUB, ALU_SLT, ALU_SLTU, // Arithmetic, compare
        ALU_MIN, ALU_MAX, ALU_MINU, ALU_MAXU,
        ALU_XOR, ALU_OR, ALU_AND, // Bitwise
        ALU_XNOR, ALU_ORN, ALU_ANDN, // Bitwise, inverted operand B
        ALU_PACK, ALU_PACKH, ALU_PACKU, // Packing
        ALU_SEXTB, ALU_SEXTH, // Sign extension
        ALU_SLL, ALU_SRL, ALU_SRA, // Shifts
        ALU_ROR, ALU_ROL, ALU_SLO, ALU_SRO, // Rotates, shift-ones
        ALU_GREV, ALU_SHFL, ALU_UNSHFL // Permutations
    } alu_op_t;

endpackage

`default_nettype wire

// ==== verilog/frv_core_pkg.sv ====
// Core data types; only RV32 is supported, so XLEN must stay 32
`default_nettype none

package frv_core_pkg;

    localparam int XLEN = 32; // Data word width
    localparam int XL   = XLEN - 1; // Top bit index

    typedef logic [XL:0] xlen_t; // One data word
    typedef logic [4:0]  reg_idx_t; // Architectural register index

endpackage

`default_nettype wire
